//--- source/audio_pkg.sv
//////////////////////////////////////////////////
// Audio sample types, volume codes and compressor
// curve constants shared by the mixer path
//////////////////////////////////////////////////

package audio_pkg;

	// Signed 16-bit sample and the 17-bit sum before clamping
	typedef logic signed [15:0] sample_t;
	typedef logic signed [16:0] wide_sample_t;

	// 5-bit volume code, 0 mutes
	typedef logic [4:0] vol_t;

	// Speaker level bit position at gain 0
	localparam int SPK_BASE_SHIFT = 11;

	//////////////////////////////////////////////////
	// Compressor breakpoints
	//////////////////////////////////////////////////

	// 2x curve
	localparam logic [15:0] COMP_X1 = 16'd14044;
	localparam logic [15:0] COMP_B1 = 16'd28088;
	localparam logic [15:0] COMP_A1 = 16'd2;
	localparam logic [15:0] COMP_F1 = 16'd4;

	// 4x curve, knee at X2 so that X2 * A2 lands on B2
	localparam logic [15:0] COMP_X2 = 16'd7400;
	localparam logic [15:0] COMP_B2 = 16'd29600;
	localparam logic [15:0] COMP_A2 = 16'd4;
	localparam logic [15:0] COMP_F2 = 16'd8;

	// Upper four code bits select the attenuation, 31 is unity
	function automatic sample_t vol_apply(input sample_t smp, input vol_t vol);
		sample_t res;
		res = '0;
		if (vol != '0) begin
			res = smp >>> (4'd15 - vol[4:1]);
		end
		return res;
	endfunction

endpackage

//--- source/mix_cfg_pkg.sv
//////////////////////////////////////////////////
// Mixer configuration types: boost mode, speaker
// gain and the activity light hold time
//////////////////////////////////////////////////

package mix_cfg_pkg;

	// Audio boost selection for the output compressor
	typedef enum logic [1:0] {
		BOOST_OFF = 2'd0,
		BOOST_2X  = 2'd1,
		BOOST_4X  = 2'd2
	} boost_e;

	// Extra left shift on the speaker level, 0 to 3
	typedef logic [1:0] spk_gain_t;

	// Roughly 0.1 s at a 45 MHz system clock
	localparam int LED_HOLD_DEFAULT = 4500000;

endpackage

//--- source/mix_ctrl_if.sv
//////////////////////////////////////////////////
// Per-source mixer controls, set at the top level
// and read by the source mixer
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface mix_ctrl_if import audio_pkg::*, mix_cfg_pkg::*; ();

	vol_t      vol_midi_l;
	vol_t      vol_midi_r;
	logic      midi_mute;
	logic      cd_en;
	spk_gain_t spk_gain;
	logic [1:0] vol_spk;

	modport ctrl (
		output vol_midi_l, vol_midi_r, midi_mute, cd_en, spk_gain, vol_spk
	);

	modport mixer (
		input vol_midi_l, vol_midi_r, midi_mute, cd_en, spk_gain, vol_spk
	);

endinterface

//--- source/source_mixer.sv
//////////////////////////////////////////////////
// Three-stage source mixer: scale, sum, clamp
//////////////////////////////////////////////////

`timescale 1ns/1ps

module source_mixer import audio_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	mix_ctrl_if.mixer ctrl,
	input  sample_t   sb_l,
	input  sample_t   sb_r,
	input  sample_t   midi_l,
	input  sample_t   midi_r,
	input  sample_t   cd_l,
	input  sample_t   cd_r,
	input  logic      speaker_out,
	output sample_t   mix_l,
	output sample_t   mix_r
);

	// Saturate a 17-bit sum to the 16-bit range
	function automatic sample_t clamp16(input wide_sample_t v);
		sample_t res;
		if (v[16] != v[15]) begin
			res = {v[16], {15{v[15]}}};
		end else begin
			res = v[15:0];
		end
		return res;
	endfunction

	sample_t spk_level;
	sample_t sb_s1_l, sb_s1_r;
	sample_t spk_s1;
	sample_t midi_s1_l, midi_s1_r;
	sample_t cd_s1_l, cd_s1_r;
	wide_sample_t sum_l, sum_r;

	// Speaker is a one-bit source, positive level or nothing
	always_comb begin
		spk_level = '0;
		if (speaker_out) begin
			spk_level = sample_t'((16'd1 << (SPK_BASE_SHIFT + ctrl.spk_gain))
				>> (2'd3 - ctrl.vol_spk));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sb_s1_l   <= '0;
			sb_s1_r   <= '0;
			spk_s1    <= '0;
			midi_s1_l <= '0;
			midi_s1_r <= '0;
			cd_s1_l   <= '0;
			cd_s1_r   <= '0;
			sum_l     <= '0;
			sum_r     <= '0;
			mix_l     <= '0;
			mix_r     <= '0;
		end else begin
			// Stage 1, per-source scaling
			sb_s1_l   <= sb_l;
			sb_s1_r   <= sb_r;
			spk_s1    <= spk_level;
			midi_s1_l <= ctrl.midi_mute ? '0 : vol_apply(midi_l, ctrl.vol_midi_l);
			midi_s1_r <= ctrl.midi_mute ? '0 : vol_apply(midi_r, ctrl.vol_midi_r);
			cd_s1_l   <= ctrl.cd_en ? cd_l : '0;
			cd_s1_r   <= ctrl.cd_en ? cd_r : '0;

			// Stage 2, sign-extended sum
			sum_l <= wide_sample_t'(sb_s1_l) + wide_sample_t'(spk_s1)
				+ wide_sample_t'(midi_s1_l) + wide_sample_t'(cd_s1_l);
			sum_r <= wide_sample_t'(sb_s1_r) + wide_sample_t'(spk_s1)
				+ wide_sample_t'(midi_s1_r) + wide_sample_t'(cd_s1_r);

			// Stage 3
			mix_l <= clamp16(sum_l);
			mix_r <= clamp16(sum_r);
		end
	end

endmodule

//--- source/output_stage.sv
//////////////////////////////////////////////////
// Output stage: optional 2x/4x compressor with an
// aligned bypass, then master volume per channel
//////////////////////////////////////////////////

`timescale 1ns/1ps

module output_stage import audio_pkg::*, mix_cfg_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  sample_t mix_l,
	input  sample_t mix_r,
	input  boost_e  boost,
	input  vol_t    vol_l,
	input  vol_t    vol_r,
	output sample_t audio_l,
	output sample_t audio_r
);

	sample_t mix_in [2];
	vol_t    vol_in [2];
	sample_t audio_q [2];

	assign mix_in[0] = mix_l;
	assign mix_in[1] = mix_r;
	assign vol_in[0] = vol_l;
	assign vol_in[1] = vol_r;

	assign audio_l = audio_q[0];
	assign audio_r = audio_q[1];

	//////////////////////////////////////////////////
	// Per-channel compressor and volume
	//////////////////////////////////////////////////

	for (genvar ch = 0; ch < 2; ch++) begin : gen_chan
		logic [15:0] mag;
		logic [15:0] curve_2x;
		logic [15:0] curve_4x;
		logic [15:0] curve_sel;
		logic [2:0]  sign_pipe;
		sample_t     comp;
		sample_t     raw_dly [4];

		always_ff @(posedge clk_sys) begin
			if (reset) begin
				mag       <= '0;
				curve_2x  <= '0;
				curve_4x  <= '0;
				curve_sel <= '0;
				sign_pipe <= '0;
				comp      <= '0;
				for (int i = 0; i < 4; i++) begin
					raw_dly[i] <= '0;
				end
				audio_q[ch] <= '0;
			end else begin
				// Magnitude, sign follows alongside
				mag       <= mix_in[ch][15] ? -mix_in[ch] : mix_in[ch];
				sign_pipe <= {sign_pipe[1:0], mix_in[ch][15]};

				// Linear gain below the knee, shallow slope above it
				curve_2x <= (mag < COMP_X1) ? mag * COMP_A1
					: (mag - COMP_X1) / COMP_F1 + COMP_B1;
				curve_4x <= (mag < COMP_X2) ? mag * COMP_A2
					: (mag - COMP_X2) / COMP_F2 + COMP_B2;

				curve_sel <= (boost == BOOST_4X) ? curve_4x : curve_2x;
				comp      <= sign_pipe[2] ? -curve_sel : curve_sel;

				// Raw mix delayed to line up with comp
				raw_dly[0] <= mix_in[ch];
				raw_dly[1] <= raw_dly[0];
				raw_dly[2] <= raw_dly[1];
				raw_dly[3] <= raw_dly[2];

				audio_q[ch] <= vol_apply((boost != BOOST_OFF) ? comp : raw_dly[3],
					vol_in[ch]);
			end
		end
	end

endmodule

//--- source/activity_led.sv
//////////////////////////////////////////////////
// Retriggerable hold timer for one activity light
//////////////////////////////////////////////////

`timescale 1ns/1ps

module activity_led import mix_cfg_pkg::*; #(
	parameter int hold_cycles = LED_HOLD_DEFAULT
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic req,
	output logic led
);

	logic [$clog2(hold_cycles + 1) - 1:0] count;

	// Any request reloads, otherwise count down to zero
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else if (req) begin
			count <= $bits(count)'(hold_cycles);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign led = (count != '0);

endmodule

//--- source/audio_mixer_top.sv
//////////////////////////////////////////////////
// Audio output path and disk activity lights,
// 8 cycles from sample inputs to audio outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_mixer_top import audio_pkg::*, mix_cfg_pkg::*; #(
	parameter int led_hold_cycles = LED_HOLD_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  sample_t    sb_l,
	input  sample_t    sb_r,
	input  sample_t    midi_l,
	input  sample_t    midi_r,
	input  sample_t    cd_l,
	input  sample_t    cd_r,
	input  logic       speaker_out,
	input  spk_gain_t  spk_gain,
	input  logic [1:0] vol_spk,
	input  vol_t       vol_midi_l,
	input  vol_t       vol_midi_r,
	input  logic       midi_mute,
	input  logic       cd_en,
	input  boost_e     boost,
	input  vol_t       vol_l,
	input  vol_t       vol_r,
	input  logic [7:0] disk_req,
	output sample_t    audio_l,
	output sample_t    audio_r,
	output logic       led_disk,
	output logic       led_user
);

	sample_t mix_l, mix_r;

	mix_ctrl_if ctrl_bus ();

	assign ctrl_bus.vol_midi_l = vol_midi_l;
	assign ctrl_bus.vol_midi_r = vol_midi_r;
	assign ctrl_bus.midi_mute  = midi_mute;
	assign ctrl_bus.cd_en      = cd_en;
	assign ctrl_bus.spk_gain   = spk_gain;
	assign ctrl_bus.vol_spk    = vol_spk;

	source_mixer source_mixer_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ctrl        (ctrl_bus.mixer),
		.sb_l        (sb_l),
		.sb_r        (sb_r),
		.midi_l      (midi_l),
		.midi_r      (midi_r),
		.cd_l        (cd_l),
		.cd_r        (cd_r),
		.speaker_out (speaker_out),
		.mix_l       (mix_l),
		.mix_r       (mix_r)
	);

	output_stage output_stage_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mix_l   (mix_l),
		.mix_r   (mix_r),
		.boost   (boost),
		.vol_l   (vol_l),
		.vol_r   (vol_r),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	// Hard disks on 5:0, floppies on 7:6
	activity_led #(.hold_cycles(led_hold_cycles)) hdd_led (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (|disk_req[5:0]),
		.led     (led_disk)
	);

	activity_led #(.hold_cycles(led_hold_cycles)) fdd_led (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (|disk_req[7:6]),
		.led     (led_user)
	);

endmodule

//--- test/tb_audio_mixer.sv
//////////////////////////////////////////////////
// Directed testbench for the audio mixer top level,
// run through build.f with run_sim.sh
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_audio_mixer import audio_pkg::*, mix_cfg_pkg::*; ();

	localparam int LED_HOLD = 50;

	logic       clk_sys = 1'b0;
	logic       reset;
	sample_t    sb_l, sb_r, midi_l, midi_r, cd_l, cd_r;
	logic       speaker_out, midi_mute, cd_en;
	spk_gain_t  spk_gain;
	logic [1:0] vol_spk;
	vol_t       vol_midi_l, vol_midi_r, vol_l, vol_r;
	boost_e     boost;
	logic [7:0] disk_req;
	sample_t    audio_l, audio_r;
	logic       led_disk, led_user;
	int         seed, errors, checks, tests;

	audio_mixer_top #(.led_hold_cycles(LED_HOLD)) audio_mixer_top_inst (
		.clk_sys (clk_sys), .reset (reset),
		.sb_l (sb_l), .sb_r (sb_r), .midi_l (midi_l), .midi_r (midi_r),
		.cd_l (cd_l), .cd_r (cd_r), .speaker_out (speaker_out),
		.spk_gain (spk_gain), .vol_spk (vol_spk),
		.vol_midi_l (vol_midi_l), .vol_midi_r (vol_midi_r),
		.midi_mute (midi_mute), .cd_en (cd_en), .boost (boost),
		.vol_l (vol_l), .vol_r (vol_r), .disk_req (disk_req),
		.audio_l (audio_l), .audio_r (audio_r),
		.led_disk (led_disk), .led_user (led_user)
	);

	initial begin
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////

	// Code 0 is silence, else shift by 15 minus the upper four bits
	function automatic sample_t vol_model(input sample_t s, input vol_t code);
		int sh;
		sample_t res;
		sh = 15 - int'(code[4:1]);
		res = 16'sd0;
		if (code != 5'd0) begin
			res = s >>> sh;
		end
		return res;
	endfunction

	function automatic int spk_model(input logic on, input spk_gain_t g, input logic [1:0] vs);
		int lvl;
		lvl = 0;
		if (on) begin
			lvl = (1 << (SPK_BASE_SHIFT + int'(g))) >> (3 - int'(vs));
		end
		return lvl;
	endfunction

	function automatic sample_t mix_model(input sample_t sb, input int spk, input sample_t midi,
		input vol_t vm, input logic mute, input sample_t cd, input logic en);
		int sum;
		sum = int'(sb) + spk;
		if (!mute) begin
			sum = sum + int'(vol_model(midi, vm));
		end
		if (en) begin
			sum = sum + int'(cd);
		end
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		return sample_t'(sum);
	endfunction

	// Linear below the knee, shallow slope above, sign restored
	function automatic sample_t comp_model(input sample_t v, input boost_e mode);
		int mag, x, b, a, f, res;
		mag = (v < 0) ? -int'(v) : int'(v);
		x = (mode == BOOST_4X) ? int'(COMP_X2) : int'(COMP_X1);
		b = (mode == BOOST_4X) ? int'(COMP_B2) : int'(COMP_B1);
		a = (mode == BOOST_4X) ? int'(COMP_A2) : int'(COMP_A1);
		f = (mode == BOOST_4X) ? int'(COMP_F2) : int'(COMP_F1);
		res = (mag < x) ? mag * a : (mag - x) / f + b;
		return sample_t'((v < 0) ? -res : res);
	endfunction

	// Random sample within half range so the 17-bit sum cannot wrap
	function automatic sample_t rand_half();
		logic signed [31:0] r;
		r = $random(seed);
		return sample_t'(r >>> 17);
	endfunction

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic check16(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_start);
	endtask

	task automatic set_quiet();
		sb_l = '0;
		sb_r = '0;
		midi_l = '0;
		midi_r = '0;
		cd_l = '0;
		cd_r = '0;
		speaker_out = 1'b0;
		spk_gain = '0;
		vol_spk = '0;
		vol_midi_l = 5'd31;
		vol_midi_r = 5'd31;
		midi_mute = 1'b1;
		cd_en = 1'b0;
		boost = BOOST_OFF;
		vol_l = 5'd31;
		vol_r = 5'd31;
		disk_req = '0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_state();
		int e0;
		e0 = errors;
		check16("audio_l", audio_l, 16'sd0);
		check16("audio_r", audio_r, 16'sd0);
		check_bit("led_disk", led_disk, 1'b0);
		check_bit("led_user", led_user, 1'b0);
		end_test("reset", e0);
	endtask

	task automatic volume_case(input sample_t s, input vol_t v);
		sb_l = s;
		sb_r = -s;
		vol_l = v;
		vol_r = v;
		wait_cycles(12);
		check16("audio_l", audio_l, vol_model(s, v));
		check16("audio_r", audio_r, vol_model(-s, v));
	endtask

	task automatic master_volume();
		int e0;
		e0 = errors;
		set_quiet();
		volume_case(16'sh5a3c, 5'd31);
		volume_case(16'sh5a3c, 5'd29);
		volume_case(16'sh5a3c, 5'd0);
		volume_case(-16'sd12345, 5'd31);
		volume_case(-16'sd12345, 5'd29);
		volume_case(-16'sd12345, 5'd0);
		end_test("master_volume", e0);
	endtask

	task automatic settle_and_check_mix();
		int spk;
		wait_cycles(12);
		spk = spk_model(speaker_out, spk_gain, vol_spk);
		check16("audio_l", audio_l,
			mix_model(sb_l, spk, midi_l, vol_midi_l, midi_mute, cd_l, cd_en));
		check16("audio_r", audio_r,
			mix_model(sb_r, spk, midi_r, vol_midi_r, midi_mute, cd_r, cd_en));
	endtask

	task automatic mix_and_clamp();
		int e0;
		logic [31:0] r;
		e0 = errors;
		set_quiet();
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			sb_l = rand_half();
			sb_r = rand_half();
			midi_l = rand_half();
			midi_r = rand_half();
			cd_l = rand_half();
			cd_r = rand_half();
			speaker_out = r[0];
			spk_gain = r[2:1];
			vol_spk = r[4:3];
			vol_midi_l = r[9:5];
			vol_midi_r = r[14:10];
			midi_mute = r[15];
			cd_en = r[16];
			settle_and_check_mix();
		end
		// Forced saturation both ways
		sb_l = 16'sd30000;
		sb_r = -16'sd30000;
		cd_l = 16'sd30000;
		cd_r = -16'sd30000;
		cd_en = 1'b1;
		midi_mute = 1'b1;
		speaker_out = 1'b1;
		settle_and_check_mix();
		check16("audio_l", audio_l, 16'sh7fff);
		check16("audio_r", audio_r, 16'sh8000);
		end_test("mixing", e0);
	endtask

	task automatic boost_case(input sample_t s, input boost_e mode, input sample_t exp);
		sb_l = s;
		sb_r = -s;
		boost = mode;
		wait_cycles(12);
		check16("audio_l", audio_l, comp_model(s, mode));
		check16("audio_r", audio_r, comp_model(-s, mode));
		check16("audio_l", audio_l, exp);
	endtask

	task automatic compressor_curve();
		int e0;
		e0 = errors;
		set_quiet();
		boost_case(16'sd1000, BOOST_2X, 16'sd2000);
		boost_case(16'sd20000, BOOST_2X, 16'sd29577);
		boost_case(-16'sd20000, BOOST_2X, -16'sd29577);
		boost_case(16'sd1000, BOOST_4X, 16'sd4000);
		end_test("compressor", e0);
	endtask

	task automatic pulse_and_hold(input int bit_idx, input logic exp_disk, input logic exp_user);
		int k;
		logic lit;
		disk_req[bit_idx] = 1'b1;
		@(negedge clk_sys);
		disk_req = '0;
		check_bit("led_disk", led_disk, exp_disk);
		check_bit("led_user", led_user, exp_user);
		k = 0;
		lit = 1'b1;
		while (lit && k < 60) begin
			@(negedge clk_sys);
			k++;
			lit = led_disk | led_user;
		end
		if (lit) begin
			$display("activity light still on 60 cycles after the last request");
			errors++;
		end else if (k != LED_HOLD) begin
			$display("activity light fell after %0d cycles instead of %0d", k, LED_HOLD);
			errors++;
		end
	endtask

	task automatic activity_lights();
		int e0;
		e0 = errors;
		set_quiet();
		pulse_and_hold(2, 1'b1, 1'b0);
		pulse_and_hold(7, 1'b0, 1'b1);
		end_test("lights", e0);
	endtask

	initial begin
		seed = 32'hb384_d5a1;
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		set_quiet();
		wait_cycles(3);
		reset = 1'b0;
		reset_state();
		master_volume();
		mix_and_clamp();
		compressor_curve();
		activity_lights();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- build.f
source/audio_pkg.sv
source/mix_cfg_pkg.sv
source/mix_ctrl_if.sv
source/source_mixer.sv
source/output_stage.sv
source/activity_led.sv
source/audio_mixer_top.sv
test/tb_audio_mixer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f \
	--top-module tb_audio_mixer -o tb_audio_mixer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_audio_mixer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
	exit 0
fi
echo "simulation did not report success"
exit 1
